// File: rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN 32

// both memories are word arrays indexed by byte address / 4
`define IMEM_WORDS 64
`define DMEM_WORDS 64

`define NUM_REGS 32

`endif

// File: rtl/isa_pkg.sv
package isa_pkg;

	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		B     = 7'b1100011,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111
	} opcode_t;

	typedef logic [4:0] reg_idx_t;
	localparam reg_idx_t X0 = 5'd0;

	// alu funct3
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// branch funct3
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;

	localparam logic [6:0] F7_SUB = 7'b0100000; // sub vs add for R type

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		opcode_t     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // sits where rd would be
		opcode_t    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_t    opcode;
	} b_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
	} instr_t;

	localparam instr_t NOP_INSTR = instr_t'(32'h0000_0013); // addi x0, x0, 0

endpackage

// File: rtl/pipe_pkg.sv
package pipe_pkg;

	// EX operand source and the store data source in MEM
	typedef enum logic [1:0] {
		RS_SEL          = 2'b00,
		EX_EX_FWD_SEL   = 2'b01, // from EX/MEM alu result
		MEM_EX_FWD_SEL  = 2'b10, // from MEM/WB write data
		MEM_MEM_FWD_SEL = 2'b11  // load data straight into a store
	} fwd_sel_t;

	// branch comparator source in decode
	typedef enum logic [1:0] {
		B_RS_SEL  = 2'b00,
		B_EX_SEL  = 2'b01,
		B_MEM_SEL = 2'b10,
		B_WB_SEL  = 2'b11
	} branch_fwd_t;

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_stage
	import isa_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              run,
	input  logic                              imem_we,
	input  logic [$clog2(`IMEM_WORDS)-1:0]    imem_addr,
	input  logic [`XLEN-1:0]                  imem_wdata,
	input  logic                              stall_if_id,
	input  logic                              flush_if_id,
	input  logic                              branch_taken,
	input  logic [`XLEN-1:0]                  branch_target,
	output instr_t                            instr_d,
	output logic [`XLEN-1:0]                  pc_d,
	output logic                              valid_d
);

	localparam int IA = $clog2(`IMEM_WORDS);

	logic [`XLEN-1:0] imem [`IMEM_WORDS];
	logic [`XLEN-1:0] pc;
	logic             run_q; // fetch begins the cycle after run rises

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q <= 1'b0;
			pc    <= '0;
		end else begin
			run_q <= run;
			if (!run_q)
				pc <= '0;
			else if (!stall_if_id)
				pc <= branch_taken ? branch_target : pc + `XLEN'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_d <= NOP_INSTR;
			valid_d <= 1'b0;
		end else if (flush_if_id || !run_q) begin
			instr_d <= NOP_INSTR; // wrong-path slot or idle
			valid_d <= 1'b0;
		end else if (!stall_if_id) begin
			instr_d <= instr_t'(imem[pc[IA+1:2]]);
			valid_d <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_if_id)
			pc_d <= pc;
	end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  instr_t            instr_d,
	input  logic [`XLEN-1:0]  pc_d,
	input  logic              valid_d,
	input  branch_fwd_t       fwd_rs1,
	input  branch_fwd_t       fwd_rs2,
	input  logic [`XLEN-1:0]  alu_x,
	input  logic [`XLEN-1:0]  alu_m,
	input  logic [`XLEN-1:0]  wdata_w,
	input  instr_t            instr_w,
	input  logic              wr_rd_w,
	input  logic              stall_if_id,
	input  logic              bubble_id_ex,
	output logic              branch_taken,
	output logic [`XLEN-1:0]  branch_target,
	output instr_t            instr_x,
	output logic [`XLEN-1:0]  pc_x,
	output logic [`XLEN-1:0]  rs1_val_x,
	output logic [`XLEN-1:0]  rs2_val_x,
	output logic [`XLEN-1:0]  imm_x,
	output logic              wr_rd_x,
	output logic              valid_x
);

	logic [`XLEN-1:0] regs [`NUM_REGS];
	logic [`XLEN-1:0] rs1_val, rs2_val;
	logic [`XLEN-1:0] cmp_a, cmp_b;       // branch / jalr operands after forwarding
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
	logic [`XLEN-1:0] jalr_sum;
	logic             rf_we;
	logic             cond;
	logic             wr_rd;
	opcode_t          op;

	assign op    = instr_d.r_fmt.opcode;
	assign rf_we = wr_rd_w && (instr_w.r_fmt.rd != X0);

	always_ff @(posedge clk) begin
		if (rf_we)
			regs[instr_w.r_fmt.rd] <= wdata_w;
	end

	// write-before-read bypass so WB and ID can share a cycle
	always_comb begin
		rs1_val = regs[instr_d.r_fmt.rs1];
		if (instr_d.r_fmt.rs1 == X0)
			rs1_val = '0;
		else if (rf_we && (instr_w.r_fmt.rd == instr_d.r_fmt.rs1))
			rs1_val = wdata_w;
		rs2_val = regs[instr_d.r_fmt.rs2];
		if (instr_d.r_fmt.rs2 == X0)
			rs2_val = '0;
		else if (rf_we && (instr_w.r_fmt.rd == instr_d.r_fmt.rs2))
			rs2_val = wdata_w;
	end

	assign imm_i = {{(`XLEN-12){instr_d.i_fmt.imm[11]}}, instr_d.i_fmt.imm};
	assign imm_s = {{(`XLEN-12){instr_d.s_fmt.imm_hi[6]}}, instr_d.s_fmt.imm_hi,
		instr_d.s_fmt.imm_lo};
	assign imm_b = {{(`XLEN-12){instr_d.b_fmt.imm_12}}, instr_d.b_fmt.imm_11,
		instr_d.b_fmt.imm_10_5, instr_d.b_fmt.imm_4_1, 1'b0};
	// J format has no view in the union
	assign imm_j = {{(`XLEN-20){instr_d[31]}}, instr_d[19:12], instr_d[20],
		instr_d[30:21], 1'b0};

	always_comb begin
		case (fwd_rs1)
			B_EX_SEL:  cmp_a = alu_x;
			B_MEM_SEL: cmp_a = alu_m;
			B_WB_SEL:  cmp_a = wdata_w;
			default:   cmp_a = rs1_val;
		endcase
		case (fwd_rs2)
			B_EX_SEL:  cmp_b = alu_x;
			B_MEM_SEL: cmp_b = alu_m;
			B_WB_SEL:  cmp_b = wdata_w;
			default:   cmp_b = rs2_val;
		endcase
	end

	always_comb begin
		case (instr_d.b_fmt.funct3)
			F3_BEQ:  cond = (cmp_a == cmp_b);
			F3_BNE:  cond = (cmp_a != cmp_b);
			F3_BLT:  cond = ($signed(cmp_a) < $signed(cmp_b));
			F3_BGE:  cond = ($signed(cmp_a) >= $signed(cmp_b));
			default: cond = 1'b0;
		endcase
	end

	assign jalr_sum     = cmp_a + imm_i;
	assign branch_taken = valid_d && ((op == JAL) || (op == JALR) || ((op == B) && cond));
	assign branch_target = (op == JAL)  ? pc_d + imm_j :
	                       (op == JALR) ? {jalr_sum[`XLEN-1:1], 1'b0} :
	                       pc_d + imm_b;

	assign wr_rd = valid_d && ((op == R) || (op == I) || (op == LOAD) ||
		(op == JAL) || (op == JALR));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_x <= NOP_INSTR;
			wr_rd_x <= 1'b0;
			valid_x <= 1'b0;
		end else if (bubble_id_ex) begin
			instr_x <= NOP_INSTR;
			wr_rd_x <= 1'b0;
			valid_x <= 1'b0;
		end else if (!stall_if_id) begin
			instr_x <= instr_d;
			wr_rd_x <= wr_rd;
			valid_x <= valid_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_if_id) begin
			pc_x      <= pc_d;
			rs1_val_x <= rs1_val;
			rs2_val_x <= rs2_val;
			imm_x     <= (op == STORE) ? imm_s : imm_i;
		end
	end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module execute_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  instr_t            instr_x,
	input  logic [`XLEN-1:0]  pc_x,
	input  logic [`XLEN-1:0]  rs1_val_x,
	input  logic [`XLEN-1:0]  rs2_val_x,
	input  logic [`XLEN-1:0]  imm_x,
	input  logic              wr_rd_x,
	input  logic              valid_x,
	input  fwd_sel_t          fwd_a,
	input  fwd_sel_t          fwd_b,
	input  logic [`XLEN-1:0]  wdata_w,
	output logic [`XLEN-1:0]  alu_x,
	output instr_t            instr_m,
	output logic [`XLEN-1:0]  alu_m,
	output logic [`XLEN-1:0]  store_val_m,
	output logic              wr_rd_m,
	output logic              valid_m
);

	logic [`XLEN-1:0] opa, opb;   // forwarded rs1 / rs2
	logic [`XLEN-1:0] op2;        // rs2 or immediate
	logic             sub;
	opcode_t          op;

	always_comb begin
		case (fwd_a)
			EX_EX_FWD_SEL:  opa = alu_m;
			MEM_EX_FWD_SEL: opa = wdata_w;
			default:        opa = rs1_val_x;
		endcase
		case (fwd_b)
			EX_EX_FWD_SEL:  opb = alu_m;
			MEM_EX_FWD_SEL: opb = wdata_w;
			default:        opb = rs2_val_x;
		endcase
	end

	assign op  = instr_x.r_fmt.opcode;
	assign op2 = (op == R) ? opb : imm_x;
	assign sub = (op == R) && (instr_x.r_fmt.funct7 == F7_SUB);

	always_comb begin
		case (instr_x.r_fmt.funct3)
			F3_ADD:  alu_x = sub ? opa - op2 : opa + op2;
			F3_SLL:  alu_x = opa << op2[4:0];
			F3_SLT:  alu_x = {{(`XLEN-1){1'b0}}, ($signed(opa) < $signed(op2))};
			F3_XOR:  alu_x = opa ^ op2;
			F3_SRL:  alu_x = opa >> op2[4:0];
			F3_OR:   alu_x = opa | op2;
			F3_AND:  alu_x = opa & op2;
			default: alu_x = opa + op2;
		endcase
		if ((op == LOAD) || (op == STORE))
			alu_x = opa + op2; // effective address as funct3 only sets the width
		else if ((op == JAL) || (op == JALR))
			alu_x = pc_x + `XLEN'd4; // link value
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_m <= NOP_INSTR;
			wr_rd_m <= 1'b0;
			valid_m <= 1'b0;
		end else begin
			instr_m <= instr_x;
			wr_rd_m <= wr_rd_x;
			valid_m <= valid_x;
		end
	end

	always_ff @(posedge clk) begin
		alu_m       <= alu_x;
		store_val_m <= opb;
	end

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module memory_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  instr_t            instr_m,
	input  logic [`XLEN-1:0]  alu_m,
	input  logic [`XLEN-1:0]  store_val_m,
	input  logic              wr_rd_m,
	input  logic              valid_m,
	input  fwd_sel_t          fwd_m2m,
	output instr_t            instr_w,
	output logic [`XLEN-1:0]  wdata_w,
	output logic              wr_rd_w,
	output logic              wb_valid,
	output reg_idx_t          wb_rd,
	output logic [`XLEN-1:0]  wb_data,
	output logic              st_valid,
	output logic [`XLEN-1:0]  st_addr,
	output logic [`XLEN-1:0]  st_data
);

	localparam int DA = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] dmem [`DMEM_WORDS];
	logic [`XLEN-1:0] store_data;
	logic [DA-1:0]    widx;
	logic             is_store;
	logic             valid_w;

	assign widx       = alu_m[DA+1:2];
	assign is_store   = valid_m && (instr_m.s_fmt.opcode == STORE);
	assign store_data = (fwd_m2m == MEM_MEM_FWD_SEL) ? wdata_w : store_val_m; // load -> store

	always_ff @(posedge clk) begin
		if (is_store)
			dmem[widx] <= store_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_w <= NOP_INSTR;
			wr_rd_w <= 1'b0;
			valid_w <= 1'b0;
		end else begin
			instr_w <= instr_m;
			wr_rd_w <= wr_rd_m;
			valid_w <= valid_m;
		end
	end

	always_ff @(posedge clk) begin
		wdata_w <= (instr_m.r_fmt.opcode == LOAD) ? dmem[widx] : alu_m;
	end

	// retire port follows the MEM/WB register
	assign wb_valid = valid_w && wr_rd_w && (instr_w.r_fmt.rd != X0);
	assign wb_rd    = instr_w.r_fmt.rd;
	assign wb_data  = wdata_w;

	assign st_valid = is_store;
	assign st_addr  = alu_m;
	assign st_data  = store_data;

endmodule

// File: rtl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  instr_t       instr_d,
	input  instr_t       instr_x,
	input  instr_t       instr_m,
	input  instr_t       instr_w,
	input  logic         wr_rd_x,
	input  logic         wr_rd_m,
	input  logic         wr_rd_w,
	input  logic         branch_taken,
	output fwd_sel_t     fwd_a,
	output fwd_sel_t     fwd_b,
	output fwd_sel_t     fwd_m2m,
	output branch_fwd_t  fwd_rs1,
	output branch_fwd_t  fwd_rs2,
	output logic         stall_if_id,
	output logic         bubble_id_ex,
	output logic         flush_if_id
);

	function automatic logic reads_rs1(opcode_t op);
		return (op == R) || (op == I) || (op == LOAD) || (op == STORE) ||
			(op == B) || (op == JALR);
	endfunction

	function automatic logic reads_rs2(opcode_t op);
		return (op == R) || (op == STORE) || (op == B);
	endfunction

	opcode_t  op_d, op_x, op_m;
	reg_idx_t rd_x, rd_m, rd_w;
	reg_idx_t rs1_d, rs2_d, rs1_x, rs2_x;
	logic     src_x, src_m, src_w;     // stage holds a live nonzero destination
	logic     hz_ex_a, hz_ex_b;        // ex to ex
	logic     hz_mem_a, hz_mem_b;      // mem to ex
	logic     hz_m2m;                  // mem to mem for store data only
	logic     br_rs1, br_rs2;          // decode compares or jumps on these
	logic     hz_bx1, hz_bx2, hz_bm1, hz_bm2, hz_bw1, hz_bw2;
	logic     load_use, load_branch;

	always_comb begin
		op_d  = instr_d.r_fmt.opcode;
		op_x  = instr_x.r_fmt.opcode;
		op_m  = instr_m.r_fmt.opcode;
		rd_x  = instr_x.r_fmt.rd;
		rd_m  = instr_m.r_fmt.rd;
		rd_w  = instr_w.r_fmt.rd;
		rs1_d = instr_d.r_fmt.rs1;
		rs2_d = instr_d.r_fmt.rs2;
		rs1_x = instr_x.r_fmt.rs1;
		rs2_x = instr_x.r_fmt.rs2;
		src_x = wr_rd_x && (rd_x != X0);
		src_m = wr_rd_m && (rd_m != X0);
		src_w = wr_rd_w && (rd_w != X0);
	end

	// a load in EX/MEM has only its address, so it never feeds EX from there
	always_comb begin
		hz_ex_a  = src_m && (op_m != LOAD) && reads_rs1(op_x) && (rd_m == rs1_x);
		hz_ex_b  = src_m && (op_m != LOAD) && reads_rs2(op_x) && (rd_m == rs2_x);
		hz_mem_a = src_w && !hz_ex_a && reads_rs1(op_x) && (rd_w == rs1_x);
		hz_mem_b = src_w && !hz_ex_b && reads_rs2(op_x) && (rd_w == rs2_x);
		hz_m2m   = src_w && (op_m == STORE) && (rd_w == instr_m.s_fmt.rs2);
	end

	assign fwd_a   = hz_ex_a ? EX_EX_FWD_SEL : hz_mem_a ? MEM_EX_FWD_SEL : RS_SEL;
	assign fwd_b   = hz_ex_b ? EX_EX_FWD_SEL : hz_mem_b ? MEM_EX_FWD_SEL : RS_SEL;
	assign fwd_m2m = hz_m2m ? MEM_MEM_FWD_SEL : RS_SEL;

	// branch and jalr operands are needed in decode
	always_comb begin
		br_rs1 = (op_d == B) || (op_d == JALR);
		br_rs2 = (op_d == B);
		hz_bx1 = br_rs1 && src_x && (rd_x == rs1_d);
		hz_bx2 = br_rs2 && src_x && (rd_x == rs2_d);
		hz_bm1 = br_rs1 && src_m && (rd_m == rs1_d);
		hz_bm2 = br_rs2 && src_m && (rd_m == rs2_d);
		hz_bw1 = br_rs1 && src_w && (rd_w == rs1_d);
		hz_bw2 = br_rs2 && src_w && (rd_w == rs2_d);
	end

	assign fwd_rs1 = hz_bx1 ? B_EX_SEL : hz_bm1 ? B_MEM_SEL : hz_bw1 ? B_WB_SEL : B_RS_SEL;
	assign fwd_rs2 = hz_bx2 ? B_EX_SEL : hz_bm2 ? B_MEM_SEL : hz_bw2 ? B_WB_SEL : B_RS_SEL;

	// store data from a load goes through m2m instead of stalling
	always_comb begin
		load_use = src_x && (op_x == LOAD) &&
			((reads_rs1(op_d) && (rd_x == rs1_d)) ||
			 (reads_rs2(op_d) && (op_d != STORE) && (rd_x == rs2_d)));
		load_branch = (op_m == LOAD) &&
			((hz_bm1 && !hz_bx1) || (hz_bm2 && !hz_bx2)); // a newer EX writer wins
	end

	assign stall_if_id  = load_use || load_branch;
	assign bubble_id_ex = stall_if_id;
	assign flush_if_id  = branch_taken && !stall_if_id; // redirect waits for valid operands

endmodule

// File: rtl/pipe_top.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module pipe_top
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              run,
	input  logic                              imem_we,
	input  logic [$clog2(`IMEM_WORDS)-1:0]    imem_addr,
	input  logic [`XLEN-1:0]                  imem_wdata,
	output logic                              wb_valid,
	output reg_idx_t                          wb_rd,
	output logic [`XLEN-1:0]                  wb_data,
	output logic                              st_valid,
	output logic [`XLEN-1:0]                  st_addr,
	output logic [`XLEN-1:0]                  st_data
);

	instr_t           instr_d, instr_x, instr_m, instr_w;
	logic [`XLEN-1:0] pc_d, pc_x;
	logic             valid_d, valid_x, valid_m;
	logic             wr_rd_x, wr_rd_m, wr_rd_w;
	logic [`XLEN-1:0] rs1_val_x, rs2_val_x, imm_x;
	logic [`XLEN-1:0] alu_x, alu_m, store_val_m, wdata_w;
	logic             branch_taken;
	logic [`XLEN-1:0] branch_target;
	fwd_sel_t         fwd_a, fwd_b, fwd_m2m;
	branch_fwd_t      fwd_rs1, fwd_rs2;
	logic             stall_if_id, bubble_id_ex, flush_if_id;

	// port names match the wires one to one
	fetch_stage u_fetch (.*);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	memory_stage u_memory (.*);

	hazard_ctrl u_hazard (.*);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 10.0
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// File: tests/pipe_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module pipe_tb;

	localparam int IA           = $clog2(`IMEM_WORDS);
	localparam int WD_PER_WORD  = 20;  // watchdog budget per program word
	localparam int WD_BASE      = 100;
	localparam int DRAIN_CYCLES = 20;  // quiet time to catch stray events

	logic             clk;
	logic             rst_n;
	logic             run;
	logic             imem_we;
	logic [IA-1:0]    imem_addr;
	logic [`XLEN-1:0] imem_wdata;
	logic             wb_valid;
	logic [4:0]       wb_rd;
	logic [`XLEN-1:0] wb_data;
	logic             st_valid;
	logic [`XLEN-1:0] st_addr;
	logic [`XLEN-1:0] st_data;

	logic [31:0] prog_addr [$];
	logic [31:0] prog_word [$];
	logic [31:0] exp_wrd [$];   // expected retire stream
	logic [31:0] exp_wdata [$];
	logic [31:0] exp_saddr [$]; // expected store stream
	logic [31:0] exp_sdata [$];

	int   n_w = 0;
	int   n_s = 0;
	int   wb_idx = 0;
	int   st_idx = 0;
	logic loaded = 1'b0;

	tb_clock clk_gen (.clk(clk));

	pipe_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.st_valid   (st_valid),
		.st_addr    (st_addr),
		.st_data    (st_data)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			fail_run("value mismatch");
		end
	endtask

	// lines are I addr word, W rd data or S addr data, hex; # starts a comment
	task automatic read_stim();
		int               fd;
		int               code;
		logic [7:0]       tag;
		logic [31:0]      f1, f2;
		logic [8*128-1:0] rest;
		fd = $fopen("tests/pipe_stim.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open tests/pipe_stim.txt");
		end else begin
			code = $fscanf(fd, "%s", tag);
			while (code == 1) begin
				if (tag == "#")
					code = $fgets(rest, fd); // skip to end of line
				else if ($fscanf(fd, "%h %h", f1, f2) != 2)
					fail_run("malformed line in the stim file");
				else if (tag == "I") begin
					prog_addr.push_back(f1);
					prog_word.push_back(f2);
				end else if (tag == "W") begin
					exp_wrd.push_back(f1);
					exp_wdata.push_back(f2);
				end else if (tag == "S") begin
					exp_saddr.push_back(f1);
					exp_sdata.push_back(f2);
				end else
					fail_run("unknown line type in the stim file");
				code = $fscanf(fd, "%s", tag);
			end
			$fclose(fd);
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		read_stim();
		n_w = exp_wrd.size();
		n_s = exp_saddr.size();
		if (prog_word.size() == 0)
			fail_run("the stim file holds no program");
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// program goes in through the load port while run is low
		foreach (prog_word[i]) begin
			@(negedge clk);
			imem_we    = 1'b1;
			imem_addr  = prog_addr[i][IA+1:2];
			imem_wdata = prog_word[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
		loaded  = 1'b1;
		@(negedge clk);
		run = 1'b1;
		wait ((wb_idx == n_w) && (st_idx == n_s));
		repeat (DRAIN_CYCLES) @(posedge clk);
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (WD_PER_WORD * prog_word.size() + WD_BASE) @(posedge clk);
		fail_run("watchdog expired: the pipeline did not retire all expected results");
	end

	always @(posedge clk) begin
		if (wb_valid) begin
			if (!run)
				fail_run("retire port fired before run was raised");
			else if (wb_idx >= n_w)
				fail_run("retire port fired after the expected list was used up");
			else begin
				check_value("retire rd", 32'(wb_rd), exp_wrd[wb_idx]);
				check_value("retire data", wb_data, exp_wdata[wb_idx]);
				wb_idx++;
			end
		end
	end

	always @(posedge clk) begin
		if (st_valid) begin
			if (!run)
				fail_run("store port fired before run was raised");
			else if (st_idx >= n_s)
				fail_run("store port fired after the expected list was used up");
			else begin
				check_value("store addr", st_addr, exp_saddr[st_idx]);
				check_value("store data", st_data, exp_sdata[st_idx]);
				st_idx++;
			end
		end
	end

endmodule

// File: files.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_ctrl.sv
rtl/pipe_top.sv
tests/tb_clock.sv
tests/pipe_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module pipe_tb -Mdir obj_dir -o pipe_sim

# the simulator exits nonzero on $fatal, the log decides the result
./obj_dir/pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

// File: tests/pipe_stim.txt
# I byte_addr instr_word | W rd data (retire order) | S addr data (store order), all hex
# text after # is ignored
I 00 12300093  # addi x1, x0, 0x123
I 04 01108113  # addi x2, x1, 0x11      ex-ex
I 08 002081B3  # add  x3, x1, x2        mem-ex and ex-ex
I 0c 40118233  # sub  x4, x3, x1
I 10 003242B3  # xor  x5, x4, x3
I 14 00128013  # addi x0, x5, 1         never retires
I 18 00506333  # or   x6, x0, x5
I 1c 00431393  # slli x7, x6, 4
I 20 0023D413  # srli x8, x7, 2
I 24 003224B3  # slt  x9, x4, x3
I 28 0F047513  # andi x10, x8, 0xf0
I 2c 02702023  # sw   x7, 0x20(x0)
I 30 02002583  # lw   x11, 0x20(x0)
I 34 00558613  # addi x12, x11, 5       load-use stall
I 38 02C02223  # sw   x12, 0x24(x0)
I 3c 02402683  # lw   x13, 0x24(x0)
I 40 02D02423  # sw   x13, 0x28(x0)     mem-mem store data
I 44 00300713  # addi x14, x0, 3
I 48 00071463  # bne  x14, x0, +8       taken, operand from ex
I 4c 7FF00793  # addi x15, x0, 0x7ff    wrong path
I 50 02002803  # lw   x16, 0x20(x0)
I 54 00E85463  # bge  x16, x14, +8      taken, load in ex
I 58 7FF00793  # addi x15, x0, 0x7ff    wrong path
I 5c 00E80463  # beq  x16, x14, +8      not taken
I 60 9D080893  # addi x17, x16, -0x630
I 64 02402903  # lw   x18, 0x24(x0)
I 68 FFF00993  # addi x19, x0, -1
I 6c 0129C463  # blt  x19, x18, +8      taken, load in mem
I 70 7FF00793  # addi x15, x0, 0x7ff    wrong path
I 74 00800A6F  # jal  x20, +8
I 78 7FF00793  # addi x15, x0, 0x7ff    wrong path
I 7c 00CA0AE7  # jalr x21, 0xc(x20)
I 80 7FF00793  # addi x15, x0, 0x7ff    wrong path
I 84 014A8B33  # add  x22, x21, x20
I 88 03602623  # sw   x22, 0x2c(x0)
I 8c 0000006F  # jal  x0, 0             park here
W 01 00000123
W 02 00000134
W 03 00000257
W 04 00000134
W 05 00000363
W 06 00000363
W 07 00003630
W 08 00000d8c
W 09 00000001
W 0a 00000080
W 0b 00003630
W 0c 00003635
W 0d 00003635
W 0e 00000003
W 10 00003630
W 11 00003000
W 12 00003635
W 13 ffffffff
W 14 00000078
W 15 00000080
W 16 000000f8
S 00000020 00003630
S 00000024 00003635
S 00000028 00003635
S 0000002c 000000f8
